/* vlog.f */
+incdir+src
src/sample_pkg.sv
src/reg_axil_slave.sv
src/sample_sequencer.sv
src/result_capture.sv
src/sample_top.sv
verif/tb_clock.sv
verif/tb_sample_top.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module tb_sample_top -o sim_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
if [ $? -ne 0 ]; then
  cat sim.log
  echo "simulation exited with an error"
  exit 1
fi

cat sim.log
if grep -q "Some tests failed" sim.log; then
  exit 1
fi
exit 0

/* verif/tb_sample_top.sv */
// Sampling controller testbench

`timescale 1ns/1ps
`default_nettype none

`include "sample_config.svh"

module tb_sample_top;

  localparam int MAX_PRE  = 60;
  localparam int N_PLAIN  = 8;
  localparam int N_AZ     = 6;
  localparam int N_GAP    = 9;
  localparam int N_STOP   = 3;
  // samples of all tests times the longest cycle, plus a margin
  localparam int LIMIT    = (N_PLAIN + 2 * N_AZ + N_GAP + N_STOP + 4) * (MAX_PRE + 45) + 3000;
  localparam logic [31:0] SEED = 32'he280d599;

  logic        clk;
  logic        reset;
  logic [3:0]  s_awaddr;
  logic        s_awvalid;
  logic        s_awready;
  logic [31:0] s_wdata;
  logic [3:0]  s_wstrb;
  logic        s_wvalid;
  logic        s_wready;
  logic [1:0]  s_bresp;
  logic        s_bvalid;
  logic        s_bready;
  logic [3:0]  s_araddr;
  logic        s_arvalid;
  logic        s_arready;
  logic [31:0] s_rdata;
  logic [1:0]  s_rresp;
  logic        s_rvalid;
  logic        s_rready;
  logic        adc_trig;
  logic        azmux;
  logic        adc_valid;
  logic [`SAMPLE_ADC_W-1:0] adc_data;
  logic        irq;

  // model state, filled by the adc responder
  logic [`SAMPLE_ADC_W-1:0] data_q[$];
  logic        mux_q[$];
  int          gap_q[$];
  int          cyc;
  int          last_valid;
  int          trig_cnt;
  int          irq_cnt;
  logic        stray_req;
  logic [31:0] rnd;
  int          checks;
  int          errors;
  int          test_err0;
  int          cur_pre;

  tb_clock u_clock (
    .clk   (clk),
    .reset (reset)
  );

  sample_top DUT (
    .clk       (clk),
    .reset     (reset),
    .s_awaddr  (s_awaddr),
    .s_awvalid (s_awvalid),
    .s_awready (s_awready),
    .s_wdata   (s_wdata),
    .s_wstrb   (s_wstrb),
    .s_wvalid  (s_wvalid),
    .s_wready  (s_wready),
    .s_bresp   (s_bresp),
    .s_bvalid  (s_bvalid),
    .s_bready  (s_bready),
    .s_araddr  (s_araddr),
    .s_arvalid (s_arvalid),
    .s_arready (s_arready),
    .s_rdata   (s_rdata),
    .s_rresp   (s_rresp),
    .s_rvalid  (s_rvalid),
    .s_rready  (s_rready),
    .adc_trig  (adc_trig),
    .azmux     (azmux),
    .adc_valid (adc_valid),
    .adc_data  (adc_data),
    .irq       (irq)
  );

  ////////////////////////////////////////////////////////////
  // helpers

  // xorshift32 step, each process keeps its own state
  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // adc word sign-extended to a register word
  function automatic logic [31:0] sext(input logic [`SAMPLE_ADC_W-1:0] d);
    return {{(32 - `SAMPLE_ADC_W){d[`SAMPLE_ADC_W-1]}}, d};
  endfunction

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("** Error %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("%s", what);
  endtask

  task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    int n;
    n = 0;
    s_awaddr  = addr;
    s_wdata   = data;
    s_wstrb   = strb;
    s_awvalid = 1'b1;
    s_wvalid  = 1'b1;
    // ready seen here means the transfer happens on the next rising edge
    do
    begin
      @(negedge clk);
      n++;
    end
    while (!s_awready && n < 50);
    @(negedge clk);
    s_awvalid = 1'b0;
    s_wvalid  = 1'b0;
    s_bready  = 1'b1;
    n = 0;
    while (!s_bvalid && n < 50)
    begin
      @(negedge clk);
      n++;
    end
    if (s_bvalid)
      compare("bresp", {30'b0, s_bresp}, 32'h0);
    @(negedge clk);
    s_bready = 1'b0;
    if (n >= 50)
      report_failure("write response never arrived");
  endtask

  task automatic axi_read(input logic [3:0] addr, output logic [31:0] data);
    int n;
    n = 0;
    s_araddr  = addr;
    s_arvalid = 1'b1;
    do
    begin
      @(negedge clk);
      n++;
    end
    while (!s_arready && n < 50);
    @(negedge clk);
    s_arvalid = 1'b0;
    n = 0;
    while (!s_rvalid && n < 50)
    begin
      @(negedge clk);
      n++;
    end
    data     = s_rdata;
    if (s_rvalid)
      compare("rresp", {30'b0, s_rresp}, 32'h0);
    s_rready = 1'b1;
    @(negedge clk);
    s_rready = 1'b0;
    if (n >= 50)
      report_failure("read data never arrived");
  endtask

  task automatic wait_irq();
    int n;
    n = 0;
    do
    begin
      @(negedge clk);
      n++;
    end
    while (!irq && n < MAX_PRE + 200);
    if (!irq)
      report_failure("no interrupt arrived within the expected time");
  endtask

  // clear run and let a pending measurement drain
  task automatic stop_run();
    axi_write(4'h0, 32'h0, 4'hF);
    repeat (cur_pre + 60) @(negedge clk);
  endtask

  task automatic start_test();
    test_err0 = errors;
    data_q.delete();
    mux_q.delete();
    gap_q.delete();
    last_valid = -1;
  endtask

  task automatic end_test(input string name);
    if (errors == test_err0)
      $display("test %s: ok", name);
    else
      $display("test %s: failed with %0d errors", name, errors - test_err0);
  endtask

  ////////////////////////////////////////////////////////////
  // adc responder and event monitor

  initial
  begin
    logic [31:0] r;
    int          delay;
    r = xorshift(SEED ^ 32'h5a5a5a5a);
    adc_valid = 1'b0;
    adc_data  = '0;
    forever
    begin
      @(negedge clk);
      if (adc_trig)
      begin
        mux_q.push_back(azmux);
        if (last_valid >= 0)
          gap_q.push_back(cyc - last_valid);
        r = xorshift(r);
        delay = 3 + int'(r % 38);
        repeat (delay) @(negedge clk);
        r = xorshift(r);
        adc_valid  = 1'b1;
        adc_data   = r[`SAMPLE_ADC_W-1:0];
        data_q.push_back(r[`SAMPLE_ADC_W-1:0]);
        last_valid = cyc;
        @(negedge clk);
        adc_valid = 1'b0;
      end
      else if (stray_req)
      begin
        // valid with no trigger outstanding
        adc_valid = 1'b1;
        adc_data  = 24'h123456;
        @(negedge clk);
        adc_valid = 1'b0;
        stray_req = 1'b0;
      end
    end
  end

  // cycle count and event counters, taken at the rising edge
  initial
  begin
    cyc      = 0;
    trig_cnt = 0;
    irq_cnt  = 0;
    forever
    begin
      @(posedge clk);
      cyc++;
      if (adc_trig)
        trig_cnt++;
      if (irq)
        irq_cnt++;
    end
  end

  // watchdog
  initial
  begin
    repeat (LIMIT) @(posedge clk);
    $display("the run timed out before all tests finished");
    $display("Some tests failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // tests

  initial
  begin
    logic [31:0] rd;
    logic [31:0] base;
    logic [31:0] pre;
    logic [31:0] v;
    logic [31:0] exp;
    logic [`SAMPLE_ADC_W-1:0] hi;
    logic [`SAMPLE_ADC_W-1:0] lo;
    logic        mh;
    logic        ml;
    int          t0;
    int          i0;
    s_awaddr  = '0;
    s_awvalid = 1'b0;
    s_wdata   = '0;
    s_wstrb   = '0;
    s_wvalid  = 1'b0;
    s_bready  = 1'b0;
    s_araddr  = '0;
    s_arvalid = 1'b0;
    s_rready  = 1'b0;
    stray_req = 1'b0;
    last_valid = -1;
    checks    = 0;
    errors    = 0;
    cur_pre   = 0;
    rnd       = SEED;
    @(negedge reset);
    @(negedge clk);

    // 1 reset values, masked read-back, read-only and unmapped writes
    start_test();
    compare("adc_trig", {31'b0, adc_trig}, 32'h0);
    compare("irq", {31'b0, irq}, 32'h0);
    axi_read(4'h0, rd);
    compare("control", rd, 32'h0);
    axi_read(4'hC, rd);
    compare("result_count", rd, 32'h0);
    axi_read(4'h4, rd);
    compare("precharge", rd, `SAMPLE_PRECHARGE_DEFAULT);
    rnd = xorshift(rnd);
    // run kept clear so no measurement starts
    v = rnd & 32'hFFFF_FFFE;
    axi_write(4'h0, v, 4'hF);
    axi_read(4'h0, rd);
    compare("control", rd, v & 32'h3);
    rnd = xorshift(rnd);
    pre = rnd;
    axi_write(4'h4, pre, 4'hF);
    axi_read(4'h4, rd);
    compare("precharge", rd, pre & 32'h00FF_FFFF);
    // partial strobes touch only their bytes
    rnd = xorshift(rnd);
    axi_write(4'h4, rnd, 4'b0101);
    exp = pre & 32'h00FF_FFFF;
    exp[7:0]   = rnd[7:0];
    exp[23:16] = rnd[23:16];
    axi_read(4'h4, rd);
    compare("precharge", rd, exp);
    axi_write(4'h8, rnd, 4'hF);
    axi_write(4'hC, rnd, 4'hF);
    axi_write(4'h2, rnd, 4'hF);
    axi_read(4'h0, rd);
    compare("control", rd, v & 32'h3);
    axi_read(4'h4, rd);
    compare("precharge", rd, exp);
    axi_read(4'hC, rd);
    compare("result_count", rd, 32'h0);
    axi_read(4'h8, rd);
    compare("result", rd, 32'h0);
    axi_read(4'h2, rd);
    compare("unmapped", rd, 32'h0);
    axi_write(4'h0, 32'h0, 4'hF);
    end_test("reset and registers");

    // 2 plain mode
    start_test();
    axi_read(4'hC, base);
    rnd = xorshift(rnd);
    cur_pre = 20 + int'(rnd % 41);
    axi_write(4'h4, cur_pre, 4'hF);
    axi_write(4'h0, 32'h1, 4'hF);
    for (int k = 0; k < N_PLAIN; k++)
    begin
      wait_irq();
      if (data_q.size() == 0 || mux_q.size() == 0)
        report_failure("interrupt without a supplied measurement");
      else
      begin
        hi = data_q.pop_front();
        mh = mux_q.pop_front();
        compare("azmux", {31'b0, mh}, 32'h0);
        axi_read(4'h8, rd);
        compare("result", rd, sext(hi));
        axi_read(4'hC, rd);
        compare("result_count", rd, base + k + 1);
      end
    end
    stop_run();
    end_test("plain mode");

    // 3 auto-zero mode, one result per hi/lo pair
    start_test();
    axi_read(4'hC, base);
    rnd = xorshift(rnd);
    cur_pre = 20 + int'(rnd % 41);
    axi_write(4'h4, cur_pre, 4'hF);
    axi_write(4'h0, 32'h3, 4'hF);
    for (int k = 0; k < N_AZ; k++)
    begin
      wait_irq();
      if (data_q.size() < 2 || mux_q.size() < 2)
        report_failure("interrupt before a full hi and lo pair was supplied");
      else
      begin
        hi = data_q.pop_front();
        lo = data_q.pop_front();
        mh = mux_q.pop_front();
        ml = mux_q.pop_front();
        compare("azmux hi", {31'b0, mh}, 32'h1);
        compare("azmux lo", {31'b0, ml}, 32'h0);
        axi_read(4'h8, rd);
        compare("result", rd, sext(hi) - sext(lo));
        axi_read(4'hC, rd);
        compare("result_count", rd, base + k + 1);
      end
    end
    stop_run();
    end_test("auto-zero mode");

    // 4 pause length between valid and the next trigger
    start_test();
    for (int r = 0; r < 3; r++)
    begin
      gap_q.delete();
      last_valid = -1;
      rnd = xorshift(rnd);
      cur_pre = int'(rnd % 16);
      axi_write(4'h4, cur_pre, 4'hF);
      axi_write(4'h0, 32'h1, 4'hF);
      for (int k = 0; k < N_GAP / 3; k++)
        wait_irq();
      axi_write(4'h0, 32'h0, 4'hF);
      foreach (gap_q[g])
      begin
        checks++;
        if (gap_q[g] < cur_pre + 2)
        begin
          errors++;
          $display("** Error adc gap got %h expected at least %h", gap_q[g], cur_pre + 2);
        end
      end
      repeat (cur_pre + 60) @(negedge clk);
    end
    end_test("precharge pause");

    // 5 stop, at most one more trigger and its interrupt
    start_test();
    rnd = xorshift(rnd);
    cur_pre = 20 + int'(rnd % 41);
    axi_write(4'h4, cur_pre, 4'hF);
    axi_write(4'h0, 32'h1, 4'hF);
    for (int k = 0; k < N_STOP; k++)
      wait_irq();
    // the counters take in the last interrupt on the next rising edge
    @(negedge clk);
    t0 = trig_cnt;
    i0 = irq_cnt;
    stop_run();
    if (trig_cnt - t0 > 1)
      report_failure("more than one trigger followed the clearing of run");
    compare("irq after stop", irq_cnt - i0, trig_cnt - t0);
    t0 = trig_cnt;
    repeat (cur_pre + 60) @(negedge clk);
    compare("triggers after stop", trig_cnt, t0);
    end_test("stop");

    // 6 stray valid with nothing outstanding
    start_test();
    axi_read(4'hC, base);
    i0 = irq_cnt;
    stray_req = 1'b1;
    repeat (10) @(negedge clk);
    compare("irq after stray valid", irq_cnt, i0);
    axi_read(4'hC, rd);
    compare("result_count", rd, base);
    end_test("stray valid");

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

/* verif/tb_clock.sv */
// Testbench clock and reset

`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk,
  output logic reset
);

  // 10 ns period
  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // reset held for 8 cycles, released on a falling edge
  initial
  begin
    reset = 1'b1;
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  end

endmodule

`default_nettype wire

/* src/sample_top.sv */
// Sampling controller top level

`timescale 1ns/1ps
`default_nettype none

`include "sample_config.svh"

module sample_top (
  input  logic                      clk,
  input  logic                      reset,
  // host side, axi4-lite slave
  input  logic [3:0]                s_awaddr,
  input  logic                      s_awvalid,
  output logic                      s_awready,
  input  logic [31:0]               s_wdata,
  input  logic [3:0]                s_wstrb,
  input  logic                      s_wvalid,
  output logic                      s_wready,
  output logic [1:0]                s_bresp,
  output logic                      s_bvalid,
  input  logic                      s_bready,
  input  logic [3:0]                s_araddr,
  input  logic                      s_arvalid,
  output logic                      s_arready,
  output logic [31:0]               s_rdata,
  output logic [1:0]                s_rresp,
  output logic                      s_rvalid,
  input  logic                      s_rready,
  // adc side
  output logic                      adc_trig,
  output logic                      azmux,
  input  logic                      adc_valid,
  input  logic [`SAMPLE_ADC_W-1:0]  adc_data,
  output logic                      irq
);

  sample_pkg::seq_cfg_t     cfg;
  sample_pkg::adc_sample_t  sample;
  sample_pkg::result_t      result;
  logic [31:0]              result_count;

  ////////////////////////////////////////////////////////////
  // host registers

  reg_axil_slave u_regs (
    .clk          (clk),
    .reset        (reset),
    .s_awaddr     (s_awaddr),
    .s_awvalid    (s_awvalid),
    .s_awready    (s_awready),
    .s_wdata      (s_wdata),
    .s_wstrb      (s_wstrb),
    .s_wvalid     (s_wvalid),
    .s_wready     (s_wready),
    .s_bresp      (s_bresp),
    .s_bvalid     (s_bvalid),
    .s_bready     (s_bready),
    .s_araddr     (s_araddr),
    .s_arvalid    (s_arvalid),
    .s_arready    (s_arready),
    .s_rdata      (s_rdata),
    .s_rresp      (s_rresp),
    .s_rvalid     (s_rvalid),
    .s_rready     (s_rready),
    .cfg          (cfg),
    .result       (result),
    .result_count (result_count)
  );

  ////////////////////////////////////////////////////////////
  // measurement cycle, adc_valid to sample is one clock

  sample_sequencer u_seq (
    .clk       (clk),
    .reset     (reset),
    .cfg       (cfg),
    .adc_trig  (adc_trig),
    .azmux     (azmux),
    .adc_valid (adc_valid),
    .adc_data  (adc_data),
    .sample    (sample)
  );

  // sample to irq is one more clock
  result_capture u_capture (
    .clk          (clk),
    .reset        (reset),
    .az_mode      (cfg.az_mode),
    .sample       (sample),
    .result       (result),
    .result_count (result_count),
    .irq          (irq)
  );

endmodule

`default_nettype wire

/* src/result_capture.sv */
// Result capture and counter

`timescale 1ns/1ps
`default_nettype none

`include "sample_config.svh"

module result_capture (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     az_mode,
  input  sample_pkg::adc_sample_t  sample,
  output sample_pkg::result_t      result,
  output logic [31:0]              result_count,
  output logic                     irq
);

  // stored hi measurement of the current auto-zero pair
  logic signed [`SAMPLE_ADC_W-1:0] hi_q;
  logic                            hi_ok;
  logic signed [`SAMPLE_ADC_W:0]   hi_ext;
  logic signed [`SAMPLE_ADC_W:0]   in_ext;
  logic signed [`SAMPLE_ADC_W:0]   value_q;
  logic                            valid_q;

  // one extra sign bit, hi - lo then cannot overflow
  assign hi_ext = {hi_q[`SAMPLE_ADC_W-1], hi_q};
  assign in_ext = {sample.data[`SAMPLE_ADC_W-1], sample.data};

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      hi_ok        <= 1'b0;
      valid_q      <= 1'b0;
      value_q      <= '0;
      result_count <= 32'h0;
    end
    else
    begin
      valid_q <= 1'b0;

      if (sample.valid)
      begin
        if (sample.phase && !az_mode)
        begin
          // plain mode, hi passes straight through
          value_q      <= in_ext;
          valid_q      <= 1'b1;
          result_count <= result_count + 1'b1;
        end
        else if (sample.phase)
          hi_ok <= 1'b1;
        else if (az_mode && hi_ok)
        begin
          // auto-zero, subtract the offset seen on reference low
          value_q      <= hi_ext - in_ext;
          valid_q      <= 1'b1;
          hi_ok        <= 1'b0;
          result_count <= result_count + 1'b1;
        end
        // lo without a stored hi is dropped
      end
    end
  end

  // hi word only
  always_ff @(posedge clk)
  begin
    if (sample.valid && sample.phase)
      hi_q <= sample.data;
  end

  assign result.value = value_q;
  assign result.valid = valid_q;

  // interrupt pulses with each new result
  assign irq = valid_q;

endmodule

`default_nettype wire

/* src/sample_sequencer.sv */
// Precharge and trigger sequencer

`timescale 1ns/1ps
`default_nettype none

`include "sample_config.svh"

module sample_sequencer (
  input  logic                      clk,
  input  logic                      reset,
  input  sample_pkg::seq_cfg_t      cfg,
  // adc handshake and input mux select
  output logic                      adc_trig,
  output logic                      azmux,
  input  logic                      adc_valid,
  input  logic [`SAMPLE_ADC_W-1:0]  adc_data,
  // measurement forwarded to the capture block
  output sample_pkg::adc_sample_t   sample
);

  // idle doubles as the pause start, where cfg is sampled
  typedef enum logic [1:0] {
    IDLE,
    PAUSE,
    TRIG,
    WAIT
  } state_t;

  state_t                    state;
  logic [`SAMPLE_CNT_W-1:0]  count_q;
  // phase of the next auto-zero measurement, 1 = hi
  logic                      hi_next;
  // phase of the measurement in progress
  logic                      phase_q;
  logic                      smp_valid;
  logic [`SAMPLE_ADC_W-1:0]  smp_data;
  logic                      smp_phase;
  logic                      accept;

  // only a measurement we asked for counts, stray valids drop out here
  assign accept = (state == WAIT) && adc_valid;

  // trigger is exactly the one cycle spent in TRIG
  assign adc_trig = (state == TRIG);

  ////////////////////////////////////////////////////////////
  // state machine

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state     <= IDLE;
      count_q   <= '0;
      hi_next   <= 1'b1;
      phase_q   <= 1'b1;
      azmux     <= 1'b0;
      smp_valid <= 1'b0;
    end
    else
    begin
      smp_valid <= 1'b0;

      case (state)
        // pause start, mode and pause length are taken here
        IDLE:
          if (cfg.run)
          begin
            count_q <= cfg.precharge_n;
            state   <= PAUSE;
            if (cfg.az_mode)
            begin
              // mux moves at the start of the pause so it can settle
              phase_q <= hi_next;
              azmux   <= hi_next;
              hi_next <= !hi_next;
            end
            else
            begin
              phase_q <= 1'b1;
              azmux   <= 1'b0;
              hi_next <= 1'b1;
            end
          end
          else
          begin
            // restart always begins with a hi measurement
            hi_next <= 1'b1;
          end

        // precharge_n+1 cycles here
        PAUSE:
          if (count_q == 0)
            state <= TRIG;
          else
            count_q <= count_q - 1'b1;

        TRIG:
          state <= WAIT;

        // run is not looked at, a started measurement completes
        WAIT:
          if (adc_valid)
          begin
            smp_valid <= 1'b1;
            azmux     <= 1'b0;
            state     <= IDLE;
          end
      endcase
    end
  end

  // measurement word and its phase tag
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      smp_data  <= adc_data;
      smp_phase <= phase_q;
    end
  end

  assign sample.data  = smp_data;
  assign sample.phase = smp_phase;
  assign sample.valid = smp_valid;

endmodule

`default_nettype wire

/* src/reg_axil_slave.sv */
// AXI4-Lite register block

`timescale 1ns/1ps
`default_nettype none

`include "sample_config.svh"

module reg_axil_slave (
  input  logic                  clk,
  input  logic                  reset,
  // write address and data channels
  input  logic [3:0]            s_awaddr,
  input  logic                  s_awvalid,
  output logic                  s_awready,
  input  logic [31:0]           s_wdata,
  input  logic [3:0]            s_wstrb,
  input  logic                  s_wvalid,
  output logic                  s_wready,
  // write response channel
  output logic [1:0]            s_bresp,
  output logic                  s_bvalid,
  input  logic                  s_bready,
  // read channels
  input  logic [3:0]            s_araddr,
  input  logic                  s_arvalid,
  output logic                  s_arready,
  output logic [31:0]           s_rdata,
  output logic [1:0]            s_rresp,
  output logic                  s_rvalid,
  input  logic                  s_rready,
  // towards the sequencer and from the capture block
  output sample_pkg::seq_cfg_t  cfg,
  input  sample_pkg::result_t   result,
  input  logic [31:0]           result_count
);

  // register map
  localparam logic [3:0] ADDR_CTRL      = 4'h0;
  localparam logic [3:0] ADDR_PRECHARGE = 4'h4;
  localparam logic [3:0] ADDR_RESULT    = 4'h8;
  localparam logic [3:0] ADDR_COUNT     = 4'hC;

  // zero padding of the precharge register and sign bits of the result
  localparam int PAD_W = 32 - `SAMPLE_CNT_W;
  localparam int EXT_W = 32 - (`SAMPLE_ADC_W + 1);

  logic [1:0]                    ctrl_q;
  logic [`SAMPLE_CNT_W-1:0]      precharge_q;
  logic signed [`SAMPLE_ADC_W:0] latest_q;
  logic                          wr_fire;
  logic                          rd_fire;
  logic [31:0]                   ctrl_wr;
  logic [31:0]                   precharge_wr;
  logic [31:0]                   rd_word;

  // merge write data into the old word, byte by byte under the strobes
  function automatic logic [31:0] apply_strb(input logic [31:0] old_word,
                                             input logic [31:0] data,
                                             input logic [3:0]  strb);
    logic [31:0] merged;
    merged = old_word;
    for (int i = 0; i < 4; i++)
    begin
      if (strb[i])
        merged[i*8 +: 8] = data[i*8 +: 8];
    end
    return merged;
  endfunction

  ////////////////////////////////////////////////////////////
  // handshakes

  // both ready lines are high together for one cycle
  assign wr_fire = s_awvalid && s_awready && s_wvalid && s_wready;
  assign rd_fire = s_arvalid && s_arready;

  // every access answers okay
  assign s_bresp = 2'b00;
  assign s_rresp = 2'b00;

  assign ctrl_wr      = apply_strb({30'b0, ctrl_q}, s_wdata, s_wstrb);
  assign precharge_wr = apply_strb({{PAD_W{1'b0}}, precharge_q}, s_wdata, s_wstrb);

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      s_awready   <= 1'b0;
      s_wready    <= 1'b0;
      s_bvalid    <= 1'b0;
      s_arready   <= 1'b0;
      s_rvalid    <= 1'b0;
      ctrl_q      <= 2'b00;
      precharge_q <= `SAMPLE_PRECHARGE_DEFAULT;
      latest_q    <= '0;
    end
    else
    begin
      // single cycle ready pulses
      s_awready <= 1'b0;
      s_wready  <= 1'b0;
      s_arready <= 1'b0;

      // accept a write only with address and data both present
      // and no response still waiting for bready
      if (s_awvalid && s_wvalid && !s_awready && !s_bvalid)
      begin
        s_awready <= 1'b1;
        s_wready  <= 1'b1;
      end

      if (wr_fire)
      begin
        s_bvalid <= 1'b1;
        // read-only and unmapped addresses fall through untouched
        case (s_awaddr)
          ADDR_CTRL:      ctrl_q      <= ctrl_wr[1:0];
          ADDR_PRECHARGE: precharge_q <= precharge_wr[`SAMPLE_CNT_W-1:0];
          default:        ;
        endcase
      end
      else if (s_bvalid && s_bready)
        s_bvalid <= 1'b0;

      // one read in flight at most
      if (s_arvalid && !s_arready && !s_rvalid)
        s_arready <= 1'b1;

      if (rd_fire)
        s_rvalid <= 1'b1;
      else if (s_rvalid && s_rready)
        s_rvalid <= 1'b0;

      // hold the newest result, the next one overwrites it
      if (result.valid)
        latest_q <= result.value;
    end
  end

  ////////////////////////////////////////////////////////////
  // read data

  always_comb
  begin
    case (s_araddr)
      ADDR_CTRL:      rd_word = {30'b0, ctrl_q};
      ADDR_PRECHARGE: rd_word = {{PAD_W{1'b0}}, precharge_q};
      ADDR_RESULT:    rd_word = {{EXT_W{latest_q[`SAMPLE_ADC_W]}}, latest_q};
      ADDR_COUNT:     rd_word = result_count;
      default:        rd_word = 32'h0;
    endcase
  end

  // data word is held until rready
  always_ff @(posedge clk)
  begin
    if (rd_fire)
      s_rdata <= rd_word;
  end

  // bit0 run, bit1 az_mode
  assign cfg.run         = ctrl_q[0];
  assign cfg.az_mode     = ctrl_q[1];
  assign cfg.precharge_n = precharge_q;

endmodule

`default_nettype wire

/* src/sample_pkg.sv */
// Sampling controller types

`default_nettype none

`include "sample_config.svh"

package sample_pkg;

  ////////////////////////////////////////////////////////////
  // host configuration seen by the sequencer

  typedef struct packed {
    // enables the measurement cycle
    logic                         run;
    // 1 for hi/lo auto-zero pairs, 0 for single hi measurements
    logic                         az_mode;
    // pause length, the pause lasts precharge_n+1 clocks
    logic [`SAMPLE_CNT_W-1:0]     precharge_n;
  } seq_cfg_t;

  ////////////////////////////////////////////////////////////
  // one measurement, tagged with the mux phase it was taken in

  typedef struct packed {
    logic signed [`SAMPLE_ADC_W-1:0] data;
    // 1 = hi (signal), 0 = lo (reference low)
    logic                            phase;
    logic                            valid;
  } adc_sample_t;

  ////////////////////////////////////////////////////////////
  // finished result, one bit wider than a sample so hi - lo fits

  typedef struct packed {
    logic signed [`SAMPLE_ADC_W:0] value;
    logic                          valid;
  } result_t;

endpackage

`default_nettype wire

/* src/sample_config.svh */
// Sampling controller configuration

`ifndef SAMPLE_CONFIG_SVH
`define SAMPLE_CONFIG_SVH

////////////////////////////////////////////////////////////
// data path widths

// width of one measurement word from the integrating adc
`define SAMPLE_ADC_W 24

// width of the precharge pause down counter
`define SAMPLE_CNT_W 24

////////////////////////////////////////////////////////////
// timing defaults

// precharge register value after reset
// 10000 clocks is 500us with a 20MHz clock
`define SAMPLE_PRECHARGE_DEFAULT 10000

`endif
